//--- hdl/stlb_pkg.sv
// TLB tag array widths, entry and request structs, SECDED encode and syndrome functions
`default_nettype none

package stlb_pkg;

	localparam int STLB_TAG_RAM_AW = 3;
	localparam int STLB_TAG_DW     = 32;
	localparam int STLB_TAG_ECC_W  = 7;
	localparam int STLB_TAG_RAM_DW = STLB_TAG_DW + STLB_TAG_ECC_W;
	localparam int STLB_MACRO_AW   = 3;  // 8 x 39 macro
	localparam int STLB_MACRO_DW   = 39;

	typedef struct packed {
		logic [19:0] vpn_tag;
		logic [8:0]  asid;
		logic        valid;
		logic        glb;      // Global page, ignores asid
		logic        pgsz;
	} tag_entry_t;

	typedef struct packed {
		logic [19:0] vpn_tag;
		logic [8:0]  asid;
	} lookup_key_t;

	typedef struct packed {
		logic                       vld;
		logic [STLB_TAG_RAM_AW-1:0] idx;
		lookup_key_t                key;
	} tag_req_t;

	typedef struct packed {
		logic                       hit;
		logic                       ecc_single;
		logic                       ecc_double;
		logic [STLB_TAG_RAM_AW-1:0] idx;
		tag_entry_t                 entry;
	} tag_result_t;

	// Hamming code positions 1..38 in bits 37:0, overall parity in bit 38
	function automatic logic [STLB_TAG_RAM_DW-1:0] ecc_encode(input logic [STLB_TAG_DW-1:0] data);
		logic [STLB_TAG_RAM_DW-1:0] code;
		logic par;
		int d;
		code = '0;
		d = 0;
		for (int p = 1; p < STLB_TAG_RAM_DW; p++) begin
			if ((p & (p - 1)) != 0) begin  // Not a check position
				code[p-1] = data[d];
				d++;
			end
		end
		for (int k = 0; k < STLB_TAG_ECC_W - 1; k++) begin
			par = 1'b0;
			for (int p = 1; p < STLB_TAG_RAM_DW; p++) begin
				if (p[k])
					par ^= code[p-1];
			end
			code[(1 << k) - 1] = par;
		end
		code[STLB_TAG_RAM_DW-1] = ^code[STLB_TAG_RAM_DW-2:0];
		return code;
	endfunction

	// Bit 6 is the overall parity error, bits 5:0 the failing code position
	function automatic logic [STLB_TAG_ECC_W-1:0] ecc_syndrome(input logic [STLB_TAG_RAM_DW-1:0] code);
		logic [STLB_TAG_ECC_W-2:0] ham;
		ham = '0;
		for (int p = 1; p < STLB_TAG_RAM_DW; p++) begin
			if (code[p-1])
				ham ^= p[STLB_TAG_ECC_W-2:0];
		end
		return {^code, ham};
	endfunction

endpackage

`default_nettype wire

//--- hdl/stlb_ram_macro.sv
// Behavioral single-port synchronous RAM with registered read
`default_nettype none

module stlb_ram_macro #(
	parameter int AW = stlb_pkg::STLB_MACRO_AW,
	parameter int DW = stlb_pkg::STLB_MACRO_DW
) (
	input  logic          clk,
	input  logic          en,
	input  logic          we,
	input  logic [AW-1:0] addr,
	input  logic [DW-1:0] din,
	output logic [DW-1:0] dout
);

	logic [DW-1:0] mem [0:(1 << AW) - 1];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
			end else begin
				dout <= mem[addr];  // Holds last read otherwise
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/stlb_tag_check.sv
// TLB tag check side: SECDED correction, tag compare and registered result
`default_nettype none

module stlb_tag_check (
	input  logic                                clk,
	input  logic                                rst_n,
	input  stlb_pkg::tag_req_t                  pend,
	input  logic [stlb_pkg::STLB_TAG_RAM_DW-1:0] stlb_rdata,
	output logic                                result_valid,
	output stlb_pkg::tag_result_t               result
);

	import stlb_pkg::*;

	logic [STLB_TAG_ECC_W-1:0]  syn;
	logic [STLB_TAG_ECC_W-2:0]  ham;
	logic                       par_err;
	logic                       sng_err;
	logic                       dbl_err;
	logic [STLB_TAG_RAM_DW-1:0] flip;
	logic [STLB_TAG_RAM_DW-1:0] fixed;
	tag_entry_t                 entry;
	logic                       hit;

	// Pull the data bits back out of code order
	function automatic tag_entry_t ecc_extract(input logic [STLB_TAG_RAM_DW-1:0] code);
		logic [STLB_TAG_DW-1:0] data;
		int d;
		data = '0;
		d = 0;
		for (int p = 1; p < STLB_TAG_RAM_DW; p++) begin
			if ((p & (p - 1)) != 0) begin
				data[d] = code[p-1];
				d++;
			end
		end
		return tag_entry_t'(data);
	endfunction

	assign syn     = ecc_syndrome(stlb_rdata);
	assign ham     = syn[STLB_TAG_ECC_W-2:0];
	assign par_err = syn[STLB_TAG_ECC_W-1];

	// Odd number of flips is treated as one, even and nonzero as two
	assign sng_err = par_err;
	assign dbl_err = (ham != '0) && !par_err;

	// Parity-only error leaves the Hamming part untouched
	assign flip  = (par_err && ham != '0) ?
		(STLB_TAG_RAM_DW'(1) << (ham - 1'b1)) : '0;
	assign fixed = stlb_rdata ^ flip;
	assign entry = ecc_extract(fixed);

	assign hit = entry.valid &&
		(entry.vpn_tag == pend.key.vpn_tag) &&
		(entry.glb || entry.asid == pend.key.asid) &&
		!dbl_err;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= pend.vld;
		end
	end

	always_ff @(posedge clk) begin
		if (pend.vld) begin
			result.hit        <= hit;
			result.ecc_single <= sng_err;
			result.ecc_double <= dbl_err;
			result.idx        <= pend.idx;
			result.entry      <= entry;
		end
	end

	// Corrected word keeps at most the parity flag
	a_sng_fixed: assert property (
		@(posedge clk) disable iff (!rst_n)
		pend.vld && sng_err |-> ecc_syndrome(fixed) inside {7'h00, 7'h40}
	) else $error("single error left a residual syndrome after correction");

endmodule

`default_nettype wire

//--- hdl/stlb_tag_ecc_ram.sv
// TLB tag RAM wrapper padding address and data to the macro size
`default_nettype none

module stlb_tag_ecc_ram (
	input  logic                                clk,
	input  logic                                stlb_cs,
	input  logic                                stlb_we,
	input  logic [stlb_pkg::STLB_TAG_RAM_AW-1:0] stlb_addr,
	input  logic [stlb_pkg::STLB_TAG_RAM_DW-1:0] stlb_wdata,
	output logic [stlb_pkg::STLB_TAG_RAM_DW-1:0] stlb_rdata,
	input  logic                                stlb_ctrl_in,
	output logic                                stlb_ctrl_out
);

	import stlb_pkg::*;

	logic [STLB_MACRO_AW-1:0] ram_addr;
	logic [STLB_MACRO_DW-1:0] ram_wdata;
	logic [STLB_MACRO_DW-1:0] ram_rdata;
	logic                     unused_ctrl_in;

	if (STLB_TAG_RAM_AW > STLB_MACRO_AW || STLB_TAG_RAM_DW > STLB_MACRO_DW) begin : gen_size_chk
		$error("Tag array does not fit the RAM macro");
	end

	assign ram_addr  = STLB_MACRO_AW'(stlb_addr);   // Zero extend
	assign ram_wdata = STLB_MACRO_DW'(stlb_wdata);

	stlb_ram_macro #(
		.AW (STLB_MACRO_AW),
		.DW (STLB_MACRO_DW)
	) u_macro (
		.clk  (clk),
		.en   (stlb_cs),
		.we   (stlb_we),
		.addr (ram_addr),
		.din  (ram_wdata),
		.dout (ram_rdata)
	);

	assign stlb_rdata = ram_rdata[STLB_TAG_RAM_DW-1:0];

	// Macro test pins not used in this design
	assign unused_ctrl_in = |stlb_ctrl_in;
	assign stlb_ctrl_out  = 1'b0;

	a_addr_known: assert property (
		@(posedge clk) stlb_cs |-> !$isunknown(stlb_addr)
	) else $error("stlb_addr unknown with stlb_cs high");

endmodule

`default_nettype wire

//--- hdl/stlb_tag_req.sv
// TLB tag request side: fill/lookup arbitration, ECC encode, fault injection, lookup pipeline
`default_nettype none

module stlb_tag_req (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                fill,
	input  logic [stlb_pkg::STLB_TAG_RAM_AW-1:0] fill_idx,
	input  stlb_pkg::tag_entry_t                fill_entry,
	input  logic                                lookup,
	input  logic [stlb_pkg::STLB_TAG_RAM_AW-1:0] lookup_idx,
	input  stlb_pkg::lookup_key_t               lookup_key,
	input  logic [stlb_pkg::STLB_TAG_RAM_DW-1:0] inj_mask,
	output logic                                stlb_cs,
	output logic                                stlb_we,
	output logic [stlb_pkg::STLB_TAG_RAM_AW-1:0] stlb_addr,
	output logic [stlb_pkg::STLB_TAG_RAM_DW-1:0] stlb_wdata,
	output stlb_pkg::tag_req_t                  pend
);

	import stlb_pkg::*;

	logic                       rd_issue;
	logic                       pend_vld;
	logic [STLB_TAG_RAM_AW-1:0] pend_idx;
	lookup_key_t                pend_key;

	// Fill has priority, a colliding lookup is dropped
	assign rd_issue = lookup & ~fill;

	assign stlb_cs    = fill | lookup;
	assign stlb_we    = fill;
	assign stlb_addr  = fill ? fill_idx : lookup_idx;
	assign stlb_wdata = ecc_encode(fill_entry) ^ inj_mask;  // Mask is zero in normal use

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend_vld <= 1'b0;
		end else begin
			pend_vld <= rd_issue;
		end
	end

	// Key rides alongside the RAM read
	always_ff @(posedge clk) begin
		if (rd_issue) begin
			pend_idx <= lookup_idx;
			pend_key <= lookup_key;
		end
	end

	assign pend = '{vld: pend_vld, idx: pend_idx, key: pend_key};

	a_fill_known: assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown({fill, fill_idx})
	) else $error("fill or fill_idx unknown");

endmodule

`default_nettype wire

//--- hdl/stlb_tag_top.sv
// TLB tag array top: request side, tag RAM wrapper and check side
`default_nettype none

module stlb_tag_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                fill,
	input  logic [stlb_pkg::STLB_TAG_RAM_AW-1:0] fill_idx,
	input  stlb_pkg::tag_entry_t                fill_entry,
	input  logic                                lookup,
	input  logic [stlb_pkg::STLB_TAG_RAM_AW-1:0] lookup_idx,
	input  stlb_pkg::lookup_key_t               lookup_key,
	input  logic [stlb_pkg::STLB_TAG_RAM_DW-1:0] inj_mask,
	output logic                                result_valid,
	output stlb_pkg::tag_result_t               result
);

	import stlb_pkg::*;

	logic                       stlb_cs;
	logic                       stlb_we;
	logic [STLB_TAG_RAM_AW-1:0] stlb_addr;
	logic [STLB_TAG_RAM_DW-1:0] stlb_wdata;
	logic [STLB_TAG_RAM_DW-1:0] stlb_rdata;
	tag_req_t                   pend;

	stlb_tag_req u_req (
		.clk        (clk),
		.rst_n      (rst_n),
		.fill       (fill),
		.fill_idx   (fill_idx),
		.fill_entry (fill_entry),
		.lookup     (lookup),
		.lookup_idx (lookup_idx),
		.lookup_key (lookup_key),
		.inj_mask   (inj_mask),
		.stlb_cs    (stlb_cs),
		.stlb_we    (stlb_we),
		.stlb_addr  (stlb_addr),
		.stlb_wdata (stlb_wdata),
		.pend       (pend)
	);

	stlb_tag_ecc_ram u_ram (
		.clk           (clk),
		.stlb_cs       (stlb_cs),
		.stlb_we       (stlb_we),
		.stlb_addr     (stlb_addr),
		.stlb_wdata    (stlb_wdata),
		.stlb_rdata    (stlb_rdata),
		.stlb_ctrl_in  (1'b0),  // Test pins idle
		.stlb_ctrl_out ()
	);

	stlb_tag_check u_check (
		.clk          (clk),
		.rst_n        (rst_n),
		.pend         (pend),
		.stlb_rdata   (stlb_rdata),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

`default_nettype wire

//--- sim/stlb_tag_tb.sv
// TLB tag array testbench: clock, reset, reference model, directed and random stimulus, checks
`default_nettype none

module stlb_tag_tb;

	import stlb_pkg::*;

	localparam int N_RANDOM   = 300;
	localparam int RST_CYCLES = 10;
	localparam int MAX_CYCLES = 2000;  // Run is about 360 cycles

	logic                       clk;
	logic                       rst_n;
	logic                       fill;
	logic [STLB_TAG_RAM_AW-1:0] fill_idx;
	tag_entry_t                 fill_entry;
	logic                       lookup;
	logic [STLB_TAG_RAM_AW-1:0] lookup_idx;
	lookup_key_t                lookup_key;
	logic [STLB_TAG_RAM_DW-1:0] inj_mask;
	logic                       result_valid;
	tag_result_t                result;

	tag_entry_t  ref_entry [0:(1 << STLB_TAG_RAM_AW) - 1];
	int          ref_flips [0:(1 << STLB_TAG_RAM_AW) - 1];  // Bits flipped by the last fill
	tag_result_t exp_q [$];
	int          issue_q [$];  // Cycle in which each lookup was driven
	int          cyc = 0;
	int unsigned seed_ret;

	stlb_tag_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.fill         (fill),
		.fill_idx     (fill_idx),
		.fill_entry   (fill_entry),
		.lookup       (lookup),
		.lookup_idx   (lookup_idx),
		.lookup_key   (lookup_key),
		.inj_mask     (inj_mask),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "Run stopped at time %0t", $time);
	endtask

	task automatic check_val(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
		assert (got_v === exp_v) else begin
			$display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, got_v);
			abort_run();
		end
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	function automatic lookup_key_t key_of(input tag_entry_t e);
		return '{vpn_tag: e.vpn_tag, asid: e.asid};
	endfunction

	function automatic tag_entry_t rand_entry();
		tag_entry_t e;
		e = tag_entry_t'($urandom);
		e.valid = ($urandom % 4) != 0;
		return e;
	endfunction

	// One or two distinct flipped positions anywhere in the stored word
	function automatic logic [STLB_TAG_RAM_DW-1:0] make_mask(input int flips);
		logic [STLB_TAG_RAM_DW-1:0] m;
		int b0;
		int b1;
		m = '0;
		b0 = $urandom % STLB_TAG_RAM_DW;
		b1 = (b0 + 1 + $urandom % (STLB_TAG_RAM_DW - 1)) % STLB_TAG_RAM_DW;
		if (flips >= 1)
			m[b0] = 1'b1;
		if (flips >= 2)
			m[b1] = 1'b1;
		return m;
	endfunction

	// One flip is corrected, two force a miss
	function automatic tag_result_t model_result(input logic [2:0] idx, input lookup_key_t key);
		tag_result_t r;
		tag_entry_t  e;
		e = ref_entry[idx];
		r.hit = e.valid && e.vpn_tag == key.vpn_tag && (e.glb || e.asid == key.asid) &&
			ref_flips[idx] < 2;
		r.ecc_single = (ref_flips[idx] == 1);
		r.ecc_double = (ref_flips[idx] == 2);
		r.idx        = idx;
		r.entry      = e;
		return r;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic put_fill(input logic [2:0] idx, input tag_entry_t e,
		input logic [STLB_TAG_RAM_DW-1:0] m, input int flips);
		fill       = 1'b1;
		fill_idx   = idx;
		fill_entry = e;
		inj_mask   = m;
		ref_entry[idx] = e;
		ref_flips[idx] = flips;
	endtask

	// Call after put_fill in the same cycle, a colliding lookup expects nothing
	task automatic put_lookup(input logic [2:0] idx, input lookup_key_t key);
		lookup     = 1'b1;
		lookup_idx = idx;
		lookup_key = key;
		if (!fill) begin
			exp_q.push_back(model_result(idx, key));
			issue_q.push_back(cyc);
		end
	endtask

	task automatic next_cycle();
		step();
		fill     = 1'b0;
		lookup   = 1'b0;
		inj_mask = '0;
	endtask

	always @(negedge clk) begin : check_results
		tag_result_t exp_r;
		int          iss;
		if (rst_n && result_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("result_valid at time %0t with no lookup outstanding", $time);
				abort_run();
			end
			exp_r = exp_q.pop_front();
			iss   = issue_q.pop_front();
			check_val("result latency cycle", iss + 2, cyc);
			check_val("result.idx", exp_r.idx, result.idx);
			check_val("result.hit", exp_r.hit, result.hit);
			check_val("result.ecc_single", exp_r.ecc_single, result.ecc_single);
			check_val("result.ecc_double", exp_r.ecc_double, result.ecc_double);
			if (!exp_r.ecc_double)
				check_val("result.entry", exp_r.entry, result.entry);
		end
	end

	initial begin
		tag_entry_t  e;
		lookup_key_t k;
		int          op;
		int          fl;
		logic [2:0]  ix;
		seed_ret   = $urandom(91);
		fill       = 1'b0;
		fill_idx   = '0;
		fill_entry = '0;
		lookup     = 1'b0;
		lookup_idx = '0;
		lookup_key = '0;
		inj_mask   = '0;
		rst_n      = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		assert (result_valid == 1'b0) else begin
			$display("result_valid high right after reset");
			abort_run();
		end

		// Fill every index, then look each one up with its own key
		for (int i = 0; i < 8; i++) begin
			e = rand_entry();
			e.valid = 1'b1;
			e.glb   = 1'b0;
			put_fill(i, e, '0, 0);
			next_cycle();
		end
		for (int i = 0; i < 8; i++) begin
			put_lookup(i, key_of(ref_entry[i]));
			next_cycle();
		end

		k = key_of(ref_entry[1]);
		k.asid = ~k.asid;  // Private entry, other asid
		put_lookup(1, k);
		next_cycle();
		e = ref_entry[2];
		e.glb = 1'b1;
		put_fill(2, e, '0, 0);
		next_cycle();
		k = key_of(e);
		k.asid = k.asid ^ 9'h05a;
		put_lookup(2, k);
		next_cycle();
		e = ref_entry[3];
		e.valid = 1'b0;
		put_fill(3, e, '0, 0);
		next_cycle();
		put_lookup(3, key_of(e));
		next_cycle();

		// Single faults on a code position and on the overall parity bit, then a double
		put_fill(4, ref_entry[4], make_mask(1), 1);
		next_cycle();
		put_lookup(4, key_of(ref_entry[4]));
		next_cycle();
		put_fill(5, ref_entry[5], {1'b1, {(STLB_TAG_RAM_DW - 1){1'b0}}}, 1);
		next_cycle();
		put_lookup(5, key_of(ref_entry[5]));
		next_cycle();
		put_fill(6, ref_entry[6], make_mask(2), 2);
		next_cycle();
		put_lookup(6, key_of(ref_entry[6]));
		next_cycle();

		for (int i = 0; i < 8; i++) begin
			put_lookup(i, key_of(ref_entry[i]));  // Back to back
			next_cycle();
		end

		// Lookup lost to a fill, then repeated
		e = rand_entry();
		e.valid = 1'b1;
		put_fill(7, e, '0, 0);
		put_lookup(7, key_of(e));
		next_cycle();
		put_lookup(7, key_of(e));
		next_cycle();

		for (int n = 0; n < N_RANDOM; n++) begin
			op = $urandom % 10;
			ix = $urandom % 8;
			if (op < 3 || op == 9) begin
				fl = ($urandom % 8 == 0) ? 1 : (($urandom % 8 == 0) ? 2 : 0);
				put_fill(ix, rand_entry(), make_mask(fl), fl);
			end
			if (op >= 3) begin
				k = key_of(ref_entry[ix]);
				if ($urandom % 4 == 0)
					k.asid = $urandom;
				if ($urandom % 8 == 0)
					k.vpn_tag = $urandom;
				put_lookup(ix, k);
			end
			next_cycle();
		end

		repeat (4) next_cycle();
		if (exp_q.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("%0d lookups never produced a result", exp_q.size());
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/stlb_pkg.sv
hdl/stlb_ram_macro.sv
hdl/stlb_tag_ecc_ram.sv
hdl/stlb_tag_req.sv
hdl/stlb_tag_check.sv
hdl/stlb_tag_top.sv
sim/stlb_tag_tb.sv
